// ==== la_isa_pkg.sv ====
package la_isa_pkg;

    localparam int xlen  = 32;
    localparam int reg_w = 5;

    typedef logic [reg_w-1:0] reg_idx_t;
    typedef logic [xlen-1:0]  word_t;

    // register fields in the instruction word
    localparam int rd_lsb = 0;
    localparam int rj_lsb = 5;
    localparam int rk_lsb = 10;

    localparam reg_idx_t link_reg = 5'd1;     // bl writes r1

    // major opcode, inst[31:26]
    localparam logic [5:0] op6_alu       = 6'h00;
    localparam logic [5:0] op6_lu12i     = 6'h05;
    localparam logic [5:0] op6_pcaddu12i = 6'h07;
    localparam logic [5:0] op6_mem       = 6'h0a;
    localparam logic [5:0] op6_jirl      = 6'h13;
    localparam logic [5:0] op6_b         = 6'h14;
    localparam logic [5:0] op6_bl        = 6'h15;
    localparam logic [5:0] op6_beq       = 6'h16;
    localparam logic [5:0] op6_bne       = 6'h17;
    localparam logic [5:0] op6_blt       = 6'h18;
    localparam logic [5:0] op6_bge       = 6'h19;
    localparam logic [5:0] op6_bltu      = 6'h1a;
    localparam logic [5:0] op6_bgeu      = 6'h1b;

    // inst[25:22]
    localparam logic [3:0] op4_reg3  = 4'h0;
    localparam logic [3:0] op4_shift = 4'h1;
    localparam logic [3:0] op4_ld_w  = 4'h2;   // under op6_mem
    localparam logic [3:0] op4_st_w  = 4'h6;   // under op6_mem
    localparam logic [3:0] op4_slti  = 4'h8;
    localparam logic [3:0] op4_sltui = 4'h9;
    localparam logic [3:0] op4_addi  = 4'ha;
    localparam logic [3:0] op4_andi  = 4'hd;
    localparam logic [3:0] op4_ori   = 4'he;
    localparam logic [3:0] op4_xori  = 4'hf;

    // inst[21:20]
    localparam logic [1:0] op2_shift = 2'h0;
    localparam logic [1:0] op2_reg3  = 2'h1;

    // inst[19:15]
    localparam logic [4:0] op5_add  = 5'h00;
    localparam logic [4:0] op5_sub  = 5'h02;
    localparam logic [4:0] op5_slt  = 5'h04;
    localparam logic [4:0] op5_sltu = 5'h05;
    localparam logic [4:0] op5_nor  = 5'h08;
    localparam logic [4:0] op5_and  = 5'h09;
    localparam logic [4:0] op5_or   = 5'h0a;
    localparam logic [4:0] op5_xor  = 5'h0b;
    localparam logic [4:0] op5_sll  = 5'h0e;
    localparam logic [4:0] op5_srl  = 5'h0f;
    localparam logic [4:0] op5_sra  = 5'h10;
    localparam logic [4:0] op5_slli = 5'h01;
    localparam logic [4:0] op5_srli = 5'h09;
    localparam logic [4:0] op5_srai = 5'h11;

    // one-hot alu operation
    typedef logic [11:0] alu_op_t;
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

endpackage

// ==== id_stage_pkg.sv ====
package id_stage_pkg;

    typedef struct packed {
        la_isa_pkg::word_t pc;
        la_isa_pkg::word_t inst;
    } fetch_bundle_t;

    // register write from a later stage
    typedef struct packed {
        logic                 we;
        la_isa_pkg::reg_idx_t waddr;
        la_isa_pkg::word_t    wdata;
    } rf_write_t;

    typedef struct packed {
        rf_write_t wr;
        logic      is_load;    // wdata is only an address
    } exe_feedback_t;

    typedef struct packed {
        logic              taken;
        la_isa_pkg::word_t target;
    } branch_redirect_t;

    typedef enum logic [3:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu,
        br_always,
        br_reg                 // jirl, target from rj
    } branch_kind_t;

    typedef struct packed {
        la_isa_pkg::alu_op_t  alu_op;
        logic                 src1_is_pc;
        logic                 src2_is_imm;
        logic                 uses_rj;
        logic                 uses_rk;
        logic                 read2_is_rd;   // second port reads rd
        logic                 rf_we;
        la_isa_pkg::reg_idx_t dest;
        logic                 res_from_mem;
        logic                 mem_we;
        branch_kind_t         br_kind;
        la_isa_pkg::word_t    imm;
        la_isa_pkg::word_t    br_offs;
    } decode_ctrl_t;

    // 116 bits to execute
    typedef struct packed {
        la_isa_pkg::alu_op_t  alu_op;
        logic                 res_from_mem;
        logic                 mem_we;
        la_isa_pkg::word_t    src1;
        la_isa_pkg::word_t    src2;
        logic                 rf_we;
        la_isa_pkg::reg_idx_t rf_waddr;
        la_isa_pkg::word_t    store_data;
    } decode_bus_t;

endpackage

// ==== inst_decoder.sv ====
`timescale 1ns/1ns

module inst_decoder (
    input  la_isa_pkg::word_t          inst,
    output id_stage_pkg::decode_ctrl_t ctrl
);
    import la_isa_pkg::*;
    import id_stage_pkg::*;

    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    reg_idx_t    rd;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    assign op6 = inst[31:26];
    assign op4 = inst[25:22];
    assign op2 = inst[21:20];
    assign op5 = inst[19:15];
    assign rd  = inst[rd_lsb +: reg_w];
    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    assign i26 = {inst[9:0], inst[25:10]};   // offs[15:0] sits in the upper half

    always_comb begin
        ctrl         = '0;
        ctrl.br_kind = br_none;
        ctrl.dest    = rd;
        ctrl.imm     = {{20{i12[11]}}, i12};
        ctrl.br_offs = {{14{i16[15]}}, i16, 2'b00};
        case (op6)
            op6_alu: begin
                if (op4 == op4_reg3 && op2 == op2_reg3) begin
                    case (op5)
                        op5_add:  ctrl.alu_op[alu_add]  = 1'b1;
                        op5_sub:  ctrl.alu_op[alu_sub]  = 1'b1;
                        op5_slt:  ctrl.alu_op[alu_slt]  = 1'b1;
                        op5_sltu: ctrl.alu_op[alu_sltu] = 1'b1;
                        op5_nor:  ctrl.alu_op[alu_nor]  = 1'b1;
                        op5_and:  ctrl.alu_op[alu_and]  = 1'b1;
                        op5_or:   ctrl.alu_op[alu_or]   = 1'b1;
                        op5_xor:  ctrl.alu_op[alu_xor]  = 1'b1;
                        op5_sll:  ctrl.alu_op[alu_sll]  = 1'b1;
                        op5_srl:  ctrl.alu_op[alu_srl]  = 1'b1;
                        op5_sra:  ctrl.alu_op[alu_sra]  = 1'b1;
                        default:  ;
                    endcase
                    ctrl.uses_rj = |ctrl.alu_op;
                    ctrl.uses_rk = |ctrl.alu_op;
                end else if (op4 == op4_shift && op2 == op2_shift) begin
                    case (op5)
                        op5_slli: ctrl.alu_op[alu_sll] = 1'b1;
                        op5_srli: ctrl.alu_op[alu_srl] = 1'b1;
                        op5_srai: ctrl.alu_op[alu_sra] = 1'b1;
                        default:  ;
                    endcase
                    ctrl.uses_rj     = |ctrl.alu_op;
                    ctrl.src2_is_imm = |ctrl.alu_op;
                end else begin
                    case (op4)
                        op4_slti:  ctrl.alu_op[alu_slt]  = 1'b1;
                        op4_sltui: ctrl.alu_op[alu_sltu] = 1'b1;
                        op4_addi:  ctrl.alu_op[alu_add]  = 1'b1;
                        op4_andi:  ctrl.alu_op[alu_and]  = 1'b1;
                        op4_ori:   ctrl.alu_op[alu_or]   = 1'b1;
                        op4_xori:  ctrl.alu_op[alu_xor]  = 1'b1;
                        default:   ;
                    endcase
                    if (op4 == op4_andi || op4 == op4_ori || op4 == op4_xori) begin
                        ctrl.imm = {20'b0, i12};     // logic ops zero-extend
                    end
                    ctrl.uses_rj     = |ctrl.alu_op;
                    ctrl.src2_is_imm = |ctrl.alu_op;
                end
            end
            op6_lu12i: begin
                ctrl.alu_op[alu_lui] = ~inst[25];
                ctrl.src2_is_imm     = 1'b1;
                ctrl.imm             = {i20, 12'b0};
            end
            op6_pcaddu12i: begin
                ctrl.alu_op[alu_add] = ~inst[25];
                ctrl.src1_is_pc      = 1'b1;
                ctrl.src2_is_imm     = 1'b1;
                ctrl.imm             = {i20, 12'b0};
            end
            op6_mem: begin
                if (op4 == op4_ld_w || op4 == op4_st_w) begin
                    ctrl.alu_op[alu_add] = 1'b1;         // address = rj + si12
                    ctrl.uses_rj         = 1'b1;
                    ctrl.src2_is_imm     = 1'b1;
                    ctrl.res_from_mem    = (op4 == op4_ld_w);
                    ctrl.mem_we          = (op4 == op4_st_w);
                    ctrl.uses_rk         = (op4 == op4_st_w);
                    ctrl.read2_is_rd     = (op4 == op4_st_w);
                end
            end
            op6_jirl: begin
                ctrl.alu_op[alu_add] = 1'b1;             // link = pc + 4
                ctrl.src1_is_pc      = 1'b1;
                ctrl.src2_is_imm     = 1'b1;
                ctrl.imm             = 32'd4;
                ctrl.uses_rj         = 1'b1;
                ctrl.br_kind         = br_reg;
            end
            op6_b: begin
                ctrl.br_kind = br_always;
                ctrl.br_offs = {{4{i26[25]}}, i26, 2'b00};
            end
            op6_bl: begin
                ctrl.alu_op[alu_add] = 1'b1;
                ctrl.src1_is_pc      = 1'b1;
                ctrl.src2_is_imm     = 1'b1;
                ctrl.imm             = 32'd4;
                ctrl.dest            = link_reg;
                ctrl.br_kind         = br_always;
                ctrl.br_offs         = {{4{i26[25]}}, i26, 2'b00};
            end
            op6_beq:  ctrl.br_kind = br_eq;
            op6_bne:  ctrl.br_kind = br_ne;
            op6_blt:  ctrl.br_kind = br_lt;
            op6_bge:  ctrl.br_kind = br_ge;
            op6_bltu: ctrl.br_kind = br_ltu;
            op6_bgeu: ctrl.br_kind = br_geu;
            default:  ;
        endcase

        // conditional branches compare rj against rd
        if (ctrl.br_kind inside {br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu}) begin
            ctrl.uses_rj     = 1'b1;
            ctrl.uses_rk     = 1'b1;
            ctrl.read2_is_rd = 1'b1;
        end

        // anything with an alu op writes back, except stores
        ctrl.rf_we = (|ctrl.alu_op) & ~ctrl.mem_we;
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ns

module regfile (
    input  logic                    clk,
    input  la_isa_pkg::reg_idx_t    raddr1,
    input  la_isa_pkg::reg_idx_t    raddr2,
    output la_isa_pkg::word_t       rdata1,
    output la_isa_pkg::word_t       rdata2,
    input  id_stage_pkg::rf_write_t wr
);
    import la_isa_pkg::*;

    word_t rf [32];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            rf[wr.waddr] <= wr.wdata;
        end
    end

    // same-cycle write is not visible here
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

// ==== operand_bypass.sv ====
`timescale 1ns/1ns

module operand_bypass (
    input  la_isa_pkg::reg_idx_t        raddr1,
    input  la_isa_pkg::reg_idx_t        raddr2,
    input  la_isa_pkg::word_t           rdata1,
    input  la_isa_pkg::word_t           rdata2,
    input  logic                        uses_rj,
    input  logic                        uses_rk,
    input  id_stage_pkg::exe_feedback_t es_fwd,
    input  id_stage_pkg::rf_write_t     ms_fwd,
    input  id_stage_pkg::rf_write_t     ws_fwd,
    output la_isa_pkg::word_t           rj_value,
    output la_isa_pkg::word_t           rkd_value,
    output logic                        stall
);
    import la_isa_pkg::*;
    import id_stage_pkg::*;

    logic hit1_es;
    logic hit1_ms;
    logic hit1_ws;
    logic hit2_es;
    logic hit2_ms;
    logic hit2_ws;

    // r0 is never a real producer
    function automatic logic hit(reg_idx_t raddr, rf_write_t prod);
        return prod.we && (prod.waddr == raddr) && (raddr != '0);
    endfunction

    assign hit1_es = hit(raddr1, es_fwd.wr);
    assign hit1_ms = hit(raddr1, ms_fwd);
    assign hit1_ws = hit(raddr1, ws_fwd);
    assign hit2_es = hit(raddr2, es_fwd.wr);
    assign hit2_ms = hit(raddr2, ms_fwd);
    assign hit2_ws = hit(raddr2, ws_fwd);

    // youngest producer wins
    assign rj_value  = hit1_es ? es_fwd.wr.wdata :
                       hit1_ms ? ms_fwd.wdata    :
                       hit1_ws ? ws_fwd.wdata    : rdata1;
    assign rkd_value = hit2_es ? es_fwd.wr.wdata :
                       hit2_ms ? ms_fwd.wdata    :
                       hit2_ws ? ws_fwd.wdata    : rdata2;

    // load data not ready until memory stage
    assign stall = es_fwd.is_load & ((hit1_es & uses_rj) | (hit2_es & uses_rk));

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/1ns

module branch_unit (
    input  id_stage_pkg::branch_kind_t kind,
    input  la_isa_pkg::word_t          pc,
    input  la_isa_pkg::word_t          rj_value,
    input  la_isa_pkg::word_t          rkd_value,
    input  la_isa_pkg::word_t          br_offs,
    output logic                       taken,
    output la_isa_pkg::word_t          target
);
    import id_stage_pkg::*;

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = (rj_value == rkd_value);
    assign lt  = ($signed(rj_value) < $signed(rkd_value));
    assign ltu = (rj_value < rkd_value);

    always_comb begin
        case (kind)
            br_eq:     taken = eq;
            br_ne:     taken = ~eq;
            br_lt:     taken = lt;
            br_ge:     taken = ~lt;
            br_ltu:    taken = ltu;
            br_geu:    taken = ~ltu;
            br_always: taken = 1'b1;
            br_reg:    taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign target = (kind == br_reg) ? rj_value + br_offs : pc + br_offs;  // jirl is rj relative

endmodule

// ==== id_stage.sv ====
`timescale 1ns/1ns

module id_stage (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           fetch_valid,
    input  id_stage_pkg::fetch_bundle_t    fetch_bundle,
    output logic                           ds_allowin,
    output id_stage_pkg::branch_redirect_t br,
    input  logic                           es_allowin,
    output logic                           ds2es_valid,
    output id_stage_pkg::decode_bus_t      ds2es_bus,
    input  id_stage_pkg::exe_feedback_t    es_fwd,
    input  id_stage_pkg::rf_write_t        ms_fwd,
    input  id_stage_pkg::rf_write_t        ws_fwd
);
    import la_isa_pkg::*;
    import id_stage_pkg::*;

    logic          ds_valid;
    fetch_bundle_t ds_fb;
    decode_ctrl_t  ctrl;
    reg_idx_t      rf_raddr1;
    reg_idx_t      rf_raddr2;
    word_t         rf_rdata1;
    word_t         rf_rdata2;
    word_t         rj_value;
    word_t         rkd_value;
    logic          stall;
    logic          ready_go;
    logic          ds_leave;
    logic          br_taken;
    word_t         br_target;

    assign ready_go    = ~stall;
    assign ds_allowin  = ~ds_valid | (ready_go & es_allowin);
    assign ds2es_valid = ds_valid & ready_go;
    assign ds_leave    = ds2es_valid & es_allowin;

    // redirect only as the branch leaves, so back-pressure cannot drop it
    assign br = '{taken: br_taken & ds_leave, target: br_target};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (br.taken) begin
            ds_valid <= 1'b0;     // wrong-path bundle dropped
        end else if (ds_allowin) begin
            ds_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && ds_allowin) begin
            ds_fb <= fetch_bundle;
        end
    end

    inst_decoder u_decoder (
        .inst (ds_fb.inst),
        .ctrl (ctrl)
    );

    assign rf_raddr1 = ds_fb.inst[rj_lsb +: reg_w];
    assign rf_raddr2 = ctrl.read2_is_rd ? ds_fb.inst[rd_lsb +: reg_w] :
                                          ds_fb.inst[rk_lsb +: reg_w];

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (ws_fwd)
    );

    operand_bypass u_bypass (
        .raddr1    (rf_raddr1),
        .raddr2    (rf_raddr2),
        .rdata1    (rf_rdata1),
        .rdata2    (rf_rdata2),
        .uses_rj   (ctrl.uses_rj),
        .uses_rk   (ctrl.uses_rk),
        .es_fwd    (es_fwd),
        .ms_fwd    (ms_fwd),
        .ws_fwd    (ws_fwd),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    branch_unit u_branch (
        .kind      (ctrl.br_kind),
        .pc        (ds_fb.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_offs   (ctrl.br_offs),
        .taken     (br_taken),
        .target    (br_target)
    );

    always_comb begin
        ds2es_bus.alu_op       = ctrl.alu_op;
        ds2es_bus.res_from_mem = ctrl.res_from_mem;
        ds2es_bus.mem_we       = ctrl.mem_we;
        ds2es_bus.src1         = ctrl.src1_is_pc ? ds_fb.pc : rj_value;
        ds2es_bus.src2         = ctrl.src2_is_imm ? ctrl.imm : rkd_value;
        ds2es_bus.rf_we        = ctrl.rf_we;
        ds2es_bus.rf_waddr     = ctrl.dest;
        ds2es_bus.store_data   = rkd_value;   // st.w reads rd on port 2
    end

endmodule

// ==== tb_id_stage.sv ====
`timescale 1ns/1ns

module tb_id_stage;
    import la_isa_pkg::*;
    import id_stage_pkg::*;

    localparam int max_cycles = 400;     // several times the length of all tests

    logic             clk;
    logic             resetn;
    logic             fetch_valid;
    fetch_bundle_t    fetch_bundle;
    logic             ds_allowin;
    branch_redirect_t br;
    logic             es_allowin;
    logic             ds2es_valid;
    decode_bus_t      ds2es_bus;
    exe_feedback_t    es_fwd;
    rf_write_t        ms_fwd;
    rf_write_t        ws_fwd;

    word_t       rf_model [32];          // expected register contents
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          cycles;

    id_stage UUT (
        .clk          (clk),
        .resetn       (resetn),
        .fetch_valid  (fetch_valid),
        .fetch_bundle (fetch_bundle),
        .ds_allowin   (ds_allowin),
        .br           (br),
        .es_allowin   (es_allowin),
        .ds2es_valid  (ds2es_valid),
        .ds2es_bus    (ds2es_bus),
        .es_fwd       (es_fwd),
        .ms_fwd       (ms_fwd),
        .ws_fwd       (ws_fwd)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the DUT stopped making progress after %0d cycles", cycles);
            $display("%0d checks, %0d errors", checks, errors);
            $display("Done: errors found");
            $finish;
        end
    end

    // galois lfsr stepped once per bit taken
    function automatic word_t rand_word();
        word_t w;
        int    i;
        w = '0;
        for (i = 0; i < 32; i++) begin
            w    = {w[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return w;
    endfunction

    function automatic alu_op_t one_hot(int pos);
        return 12'd1 << pos;
    endfunction

    function automatic word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t enc_3r(logic [4:0] op5, reg_idx_t rk, reg_idx_t rj, reg_idx_t rd);
        return {op6_alu, op4_reg3, op2_reg3, op5, rk, rj, rd};
    endfunction

    function automatic word_t enc_shift(logic [4:0] op5, logic [4:0] ui5, reg_idx_t rj,
                                        reg_idx_t rd);
        return {op6_alu, op4_shift, op2_shift, op5, ui5, rj, rd};
    endfunction

    function automatic word_t enc_i12(logic [5:0] op6, logic [3:0] op4, logic [11:0] i12,
                                      reg_idx_t rj, reg_idx_t rd);
        return {op6, op4, i12, rj, rd};
    endfunction

    function automatic word_t enc_i20(logic [5:0] op6, logic [19:0] i20, reg_idx_t rd);
        return {op6, 1'b0, i20, rd};
    endfunction

    function automatic word_t enc_i16(logic [5:0] op6, logic [15:0] offs, reg_idx_t rj,
                                      reg_idx_t rd);
        return {op6, offs, rj, rd};
    endfunction

    function automatic word_t enc_i26(logic [5:0] op6, logic [25:0] offs);
        return {op6, offs[15:0], offs[25:16]};   // low half of offset sits on top
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // write-back port doubles as the preload path
    task automatic preload(input reg_idx_t idx, input word_t val);
        @(posedge clk);
        ws_fwd <= '{we: 1'b1, waddr: idx, wdata: val};
        @(posedge clk);
        ws_fwd <= '0;
        rf_model[idx] = val;
    endtask

    // returns right after the edge that accepts the bundle
    task automatic send(input word_t pc, input word_t inst);
        @(posedge clk);
        fetch_valid  <= 1'b1;
        fetch_bundle <= '{pc: pc, inst: inst};
        @(negedge clk);
        while (!ds_allowin) @(negedge clk);
        @(posedge clk);
        fetch_valid <= 1'b0;
    endtask

    // ends at the falling edge of the cycle the instruction is offered to execute
    task automatic decode(input word_t pc, input word_t inst);
        send(pc, inst);
        @(negedge clk);
        while (!ds2es_valid) @(negedge clk);
    endtask

    task automatic test_reset();
        @(negedge clk);
        check("ds2es_valid after reset", 32'(ds2es_valid), 32'd0);
        check("br.taken after reset", 32'(br.taken), 32'd0);
        check("ds_allowin after reset", 32'(ds_allowin), 32'd1);
    endtask

    task automatic test_alu();
        word_t pc;
        word_t inst;
        pc = 32'h1c00_0040;
        decode(pc, enc_3r(op5_add, 5'd5, 5'd4, 5'd3));
        check("alu_op add.w", 32'(ds2es_bus.alu_op), 32'(one_hot(alu_add)));
        check("rf_waddr add.w", 32'(ds2es_bus.rf_waddr), 32'd3);
        check("rf_we add.w", 32'(ds2es_bus.rf_we), 32'd1);
        check("src1 add.w", ds2es_bus.src1, rf_model[4]);
        check("src2 add.w", ds2es_bus.src2, rf_model[5]);
        decode(pc + 4, enc_3r(op5_sub, 5'd7, 5'd6, 5'd2));
        check("alu_op sub.w", 32'(ds2es_bus.alu_op), 32'(one_hot(alu_sub)));
        check("src2 sub.w", ds2es_bus.src2, rf_model[7]);
        decode(pc + 8, enc_i12(op6_alu, op4_addi, 12'h9a5, 5'd8, 5'd4));
        check("alu_op addi.w", 32'(ds2es_bus.alu_op), 32'(one_hot(alu_add)));
        check("rf_waddr addi.w", 32'(ds2es_bus.rf_waddr), 32'd4);
        check("src1 addi.w", ds2es_bus.src1, rf_model[8]);
        check("src2 addi.w", ds2es_bus.src2, sext12(12'h9a5));
        decode(pc + 12, enc_i12(op6_alu, op4_andi, 12'hf0f, 5'd9, 5'd5));
        check("alu_op andi", 32'(ds2es_bus.alu_op), 32'(one_hot(alu_and)));
        check("src2 andi", ds2es_bus.src2, {20'b0, 12'hf0f});    // zero extended
        inst = enc_shift(op5_srai, 5'd7, 5'd10, 5'd6);
        decode(pc + 16, inst);
        check("alu_op srai.w", 32'(ds2es_bus.alu_op), 32'(one_hot(alu_sra)));
        check("src1 srai.w", ds2es_bus.src1, rf_model[10]);
        check("src2 srai.w", ds2es_bus.src2, 32'h0000_0227);     // op2, op5 and ui5 bits
        decode(pc + 20, enc_i20(op6_lu12i, 20'habcde, 5'd7));
        check("alu_op lu12i.w", 32'(ds2es_bus.alu_op), 32'(one_hot(alu_lui)));
        check("rf_waddr lu12i.w", 32'(ds2es_bus.rf_waddr), 32'd7);
        check("src2 lu12i.w", ds2es_bus.src2, 32'habcd_e000);
        decode(pc + 24, enc_i20(op6_pcaddu12i, 20'h00012, 5'd8));
        check("alu_op pcaddu12i", 32'(ds2es_bus.alu_op), 32'(one_hot(alu_add)));
        check("src1 pcaddu12i", ds2es_bus.src1, pc + 24);
        check("src2 pcaddu12i", ds2es_bus.src2, 32'h0001_2000);
    endtask

    task automatic test_forwarding();
        word_t a;
        word_t b;
        word_t c;
        a = rand_word();
        b = rand_word();
        c = rand_word();
        @(posedge clk);
        es_allowin <= 1'b0;              // keep the add sitting in decode
        send(32'h1c00_0080, enc_3r(op5_add, 5'd0, 5'd8, 5'd2));
        ws_fwd <= '{we: 1'b1, waddr: 5'd8, wdata: a};
        ms_fwd <= '{we: 1'b1, waddr: 5'd8, wdata: b};
        es_fwd <= '{wr: '{we: 1'b1, waddr: 5'd8, wdata: c}, is_load: 1'b0};
        @(negedge clk);
        check("src1 with all three producers", ds2es_bus.src1, c);
        @(posedge clk);
        es_fwd <= '0;
        @(negedge clk);
        check("src1 with memory and write-back", ds2es_bus.src1, b);
        @(posedge clk);
        ms_fwd <= '0;
        ws_fwd <= '0;
        es_fwd <= '{wr: '{we: 1'b1, waddr: 5'd0, wdata: c}, is_load: 1'b0};
        rf_model[8] = a;                 // write-back landed in the regfile
        @(negedge clk);
        check("src2 with producer on r0", ds2es_bus.src2, 32'd0);
        check("src1 from regfile", ds2es_bus.src1, rf_model[8]);
        @(posedge clk);
        es_fwd     <= '0;
        es_allowin <= 1'b1;
    endtask

    task automatic test_load_use();
        word_t       d;
        decode_bus_t held;
        d = rand_word();
        @(posedge clk);
        es_fwd <= '{wr: '{we: 1'b1, waddr: 5'd9, wdata: rand_word()}, is_load: 1'b1};
        send(32'h1c00_00c0, enc_3r(op5_add, 5'd5, 5'd9, 5'd3));
        repeat (2) begin
            @(negedge clk);
            check("ds2es_valid during load-use", 32'(ds2es_valid), 32'd0);
            check("ds_allowin during load-use", 32'(ds_allowin), 32'd0);
        end
        @(posedge clk);
        es_fwd     <= '0;
        ms_fwd     <= '{we: 1'b1, waddr: 9, wdata: d};   // load moved on to memory
        es_allowin <= 1'b0;
        @(negedge clk);
        check("ds2es_valid after load", 32'(ds2es_valid), 32'd1);
        check("src1 after load", ds2es_bus.src1, d);
        check("ds_allowin with es_allowin low", 32'(ds_allowin), 32'd0);
        held = ds2es_bus;
        @(posedge clk);
        fetch_valid  <= 1'b1;            // next bundle waits behind the held add
        fetch_bundle <= '{pc: 32'h1c00_00c4, inst: enc_3r(op5_sub, 5'd7, 5'd6, 5'd2)};
        @(posedge clk);
        @(negedge clk);
        check("ds2es_valid while held", 32'(ds2es_valid), 32'd1);
        check("ds2es_bus held unchanged", 32'(ds2es_bus == held), 32'd1);
        check("ds_allowin still low", 32'(ds_allowin), 32'd0);
        @(posedge clk);
        fetch_valid <= 1'b0;
        es_allowin  <= 1'b1;
        ms_fwd      <= '0;
    endtask

    task automatic test_branches();
        word_t pc;
        preload(5'd11, rf_model[10]);    // equal operands for beq
        pc = 32'h1c00_0100;
        send(pc, enc_i16(op6_beq, 16'hfff0, 5'd10, 5'd11));
        fetch_valid  <= 1'b1;            // wrong-path bundle
        fetch_bundle <= '{pc: pc + 4, inst: enc_3r(op5_add, 5'd2, 5'd2, 5'd3)};
        @(negedge clk);
        check("ds2es_valid beq", 32'(ds2es_valid), 32'd1);
        check("br.taken beq", 32'(br.taken), 32'd1);
        check("br.target beq", br.target, pc - 32'h40);          // 16 words back
        @(posedge clk);
        fetch_valid <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check("ds2es_valid after redirect", 32'(ds2es_valid), 32'd0);
            check("br.taken after redirect", 32'(br.taken), 32'd0);
        end
        decode(pc + 32'h40, enc_i16(op6_bltu, 16'h0020, 5'd10, 5'd11));
        check("br.taken bltu", 32'(br.taken), 32'd0);
        check("rf_we bltu", 32'(ds2es_bus.rf_we), 32'd0);
        decode(pc + 32'h80, enc_i26(op6_bl, 26'h000_0123));
        check("br.taken bl", 32'(br.taken), 32'd1);
        check("br.target bl", br.target, pc + 32'h80 + 32'h48c);
        check("rf_waddr bl", 32'(ds2es_bus.rf_waddr), 32'(link_reg));
        check("rf_we bl", 32'(ds2es_bus.rf_we), 32'd1);
        check("src1 bl", ds2es_bus.src1, pc + 32'h80);
        check("src2 bl", ds2es_bus.src2, 32'd4);
        decode(pc + 32'hc0, enc_i16(op6_jirl, 16'h0010, 5'd7, 5'd5));
        check("br.taken jirl", 32'(br.taken), 32'd1);
        check("br.target jirl", br.target, rf_model[7] + 32'h40);
        check("rf_waddr jirl", 32'(ds2es_bus.rf_waddr), 32'd5);
    endtask

    task automatic test_memory();
        word_t pc;
        pc = 32'h1c00_0200;
        decode(pc, enc_i12(op6_mem, op4_st_w, 12'h804, 5'd6, 5'd5));
        check("mem_we st.w", 32'(ds2es_bus.mem_we), 32'd1);
        check("rf_we st.w", 32'(ds2es_bus.rf_we), 32'd0);
        check("store_data st.w", ds2es_bus.store_data, rf_model[5]);
        check("src1 st.w", ds2es_bus.src1, rf_model[6]);
        check("src2 st.w", ds2es_bus.src2, sext12(12'h804));
        decode(pc + 4, enc_i12(op6_mem, op4_ld_w, 12'h010, 5'd4, 5'd7));
        check("res_from_mem ld.w", 32'(ds2es_bus.res_from_mem), 32'd1);
        check("rf_we ld.w", 32'(ds2es_bus.rf_we), 32'd1);
        check("mem_we ld.w", 32'(ds2es_bus.mem_we), 32'd0);
        decode(pc + 8, 32'hffff_ffff);   // no such opcode
        check("rf_we unknown", 32'(ds2es_bus.rf_we), 32'd0);
        check("mem_we unknown", 32'(ds2es_bus.mem_we), 32'd0);
    endtask

    initial begin
        int i;
        lfsr         = 32'hb6d8_00fd;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        rf_model     = '{default: '0};
        resetn       = 1'b0;
        fetch_valid  = 1'b0;
        fetch_bundle = '0;
        es_allowin   = 1'b1;
        es_fwd       = '0;
        ms_fwd       = '0;
        ws_fwd       = '0;
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
        test_reset();
        for (i = 2; i < 12; i++) begin
            preload(5'(i), rand_word());
        end
        test_alu();
        test_forwarding();
        test_load_use();
        test_branches();
        test_memory();
        repeat (2) @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== files.f ====
la_isa_pkg.sv
id_stage_pkg.sv
inst_decoder.sv
regfile.sv
operand_bypass.sv
branch_unit.sv
id_stage.sv
tb_id_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f files.f --top-module tb_id_stage -o tb_id_stage_sim
./obj_dir/tb_id_stage_sim > sim.log 2>&1
cat sim.log
if grep -qx "Done: no errors" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
